// ==== run.sh ====
#!/bin/sh
# build and run the block reorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_block_reorder \
    --Mdir "$OBJ" \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_block_reorder" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
src/blk_pkg.sv
src/burst_fsm.sv
src/raster_write_counter.sv
src/block_buffer_ram.sv
src/block_read_fsm.sv
src/block_read_counter.sv
src/block_reorder_top.sv
tests/block_reorder_assertions.sv
tests/block_checker.sv
tests/tb_block_reorder.sv

// ==== src/blk_pkg.sv ====
package blk_pkg;

    // pixel and frame dimensions
    localparam int PIX_W = 24;
    localparam int DIM_W = 12;

    // 8x8 block geometry
    localparam int BLK_SIDE = 8;
    localparam int BLK_PIX  = 64;

    // every burst request asks for the same length
    localparam logic [7:0] BURST_LEN = 8'd255;

    // fill for positions outside the image
    localparam logic [PIX_W-1:0] PAD_PIXEL = '0;

    typedef logic [PIX_W-1:0] pixel_t;

    typedef struct packed {
        logic [DIM_W-1:0] width;
        logic [DIM_W-1:0] height;
        logic [8:0]       blk_cols;
        logic [8:0]       blk_rows;
    } frame_geom_t;

    typedef struct packed {
        logic       bank;
        logic       last_line;
        logic [8:0] blk_col;
        logic       frame_written;
    } wr_progress_t;

    typedef struct packed {
        logic       bank;
        logic [8:0] blk_col;
        logic [8:0] blk_row;
        logic [2:0] row;
        logic [2:0] col;
    } rd_pos_t;

    typedef struct packed {
        pixel_t pixel;
        logic   block_end;
        logic   frame_end;
    } out_beat_t;

endpackage

// ==== src/block_buffer_ram.sv ====
`timescale 1ns/100ps

module block_buffer_ram #(
    parameter  int MAX_BLOCKS_X = 256,
    localparam int ADDR_W       = $clog2(MAX_BLOCKS_X * blk_pkg::BLK_PIX) + 1
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                we,
    input  logic [ADDR_W-1:0]   waddr,
    input  blk_pkg::pixel_t     wdata,
    input  logic                rd_step,
    input  logic [ADDR_W-1:0]   raddr,
    input  logic                pad,
    input  logic                block_end,
    input  logic                frame_end,
    output logic                out_valid,
    output blk_pkg::out_beat_t  out_beat
);

    // two banks of one strip each
    blk_pkg::pixel_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // flags ride along with the pixel they belong to
    always_ff @(posedge clk) begin
        if (rd_step) begin
            out_beat.pixel     <= pad ? blk_pkg::PAD_PIXEL : mem[raddr];
            out_beat.block_end <= block_end;
            out_beat.frame_end <= frame_end;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) out_valid <= 1'b0;
        else       out_valid <= rd_step;
    end

endmodule

// ==== src/block_read_counter.sv ====
`timescale 1ns/100ps

module block_read_counter #(
    parameter  int MAX_BLOCKS_X = 256,
    parameter  int GAP_CYCLES   = 13,
    localparam int ADDR_W       = $clog2(MAX_BLOCKS_X * blk_pkg::BLK_PIX) + 1
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 frame_start,
    input  logic                 rd_step,
    input  logic                 gap_active,
    input  blk_pkg::frame_geom_t geom,
    output blk_pkg::rd_pos_t     rd_pos,
    output logic                 block_end,
    output logic                 frame_end,
    output logic                 gap_done,
    output logic                 pad,
    output logic [ADDR_W-1:0]    raddr
);

    localparam int COL_W = $clog2(MAX_BLOCKS_X);
    localparam int GAP_W = $clog2(GAP_CYCLES + 1);

    logic [GAP_W-1:0]          gap_cnt;
    logic                      last_col;
    logic                      last_row;
    logic [blk_pkg::DIM_W-1:0] pix_x;
    logic [blk_pkg::DIM_W-1:0] pix_y;

    assign last_col  = (rd_pos.blk_col == geom.blk_cols - 9'd1);
    assign last_row  = (rd_pos.blk_row == geom.blk_rows - 9'd1);
    assign block_end = ({rd_pos.row, rd_pos.col} == 6'(blk_pkg::BLK_PIX - 1));
    assign frame_end = block_end && last_col && last_row;

    // bank is not cleared per frame, it tracks the writer strip for strip
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_pos <= '0;
        end else if (frame_start) begin
            rd_pos.blk_col <= '0;
            rd_pos.blk_row <= '0;
            rd_pos.row     <= '0;
            rd_pos.col     <= '0;
        end else if (rd_step) begin
            {rd_pos.row, rd_pos.col} <= {rd_pos.row, rd_pos.col} + 6'd1;
            if (block_end) begin
                if (last_col) begin
                    rd_pos.blk_col <= '0;
                    rd_pos.blk_row <= rd_pos.blk_row + 9'd1;
                    rd_pos.bank    <= ~rd_pos.bank;
                end else begin
                    rd_pos.blk_col <= rd_pos.blk_col + 9'd1;
                end
            end
        end
    end

    // idle cycles after each block
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)           gap_cnt <= '0;
        else if (gap_active) gap_cnt <= gap_cnt + 1'b1;
        else                 gap_cnt <= '0;
    end

    assign gap_done = gap_active && (gap_cnt == GAP_W'(GAP_CYCLES - 1));

    // image coordinate of the pixel being read
    assign pix_x = {rd_pos.blk_col, rd_pos.col};
    assign pix_y = {rd_pos.blk_row, rd_pos.row};
    assign pad   = (pix_x >= geom.width) || (pix_y >= geom.height);

    assign raddr = {rd_pos.bank, rd_pos.blk_col[COL_W-1:0], rd_pos.row, rd_pos.col};

endmodule

// ==== src/block_read_fsm.sv ====
`timescale 1ns/100ps

module block_read_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  frame_start,
    input  logic                  downstream_almost_full,
    input  blk_pkg::wr_progress_t wr_progress,
    input  blk_pkg::rd_pos_t      rd_pos,
    input  logic                  block_end,
    input  logic                  frame_end,
    input  logic                  gap_done,
    output logic                  rd_step,
    output logic                  gap_active
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DATA,
        ST_GAP
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   blk_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= ST_IDLE;
        else       state <= state_nxt;
    end

    // other bank means a whole strip is waiting;
    // same bank needs the writer on the last strip line beyond this column
    assign blk_ready = (rd_pos.bank != wr_progress.bank) ||
                       (wr_progress.last_line && (wr_progress.blk_col > rd_pos.blk_col));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (frame_start) state_nxt = ST_WAIT;
            end
            ST_WAIT: begin
                if (blk_ready && !downstream_almost_full) state_nxt = ST_DATA;
            end
            // once started, a block always runs to its 64th pixel
            ST_DATA: begin
                if (block_end) state_nxt = frame_end ? ST_IDLE : ST_GAP;
            end
            ST_GAP: begin
                if (gap_done) state_nxt = ST_WAIT;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign rd_step    = (state == ST_DATA);
    assign gap_active = (state == ST_GAP);

endmodule

// ==== src/block_reorder_top.sv ====
`timescale 1ns/100ps

module block_reorder_top #(
    parameter int MAX_BLOCKS_X = 256,
    parameter int GAP_CYCLES   = 13
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      frame_done,
    input  logic [blk_pkg::DIM_W-1:0] pixel_x,
    input  logic [blk_pkg::DIM_W-1:0] pixel_y,
    output logic                      burst_valid,
    output logic [7:0]                burst_len,
    input  logic                      burst_ready,
    input  logic                      wr_valid,
    input  logic [31:0]               wr_data,
    input  logic                      wr_last,
    output logic                      wr_data_ready,
    input  logic                      downstream_almost_full,
    output logic                      out_valid,
    output blk_pkg::out_beat_t        out_beat
);

    localparam int ADDR_W = $clog2(MAX_BLOCKS_X * blk_pkg::BLK_PIX) + 1;

    logic                  wr_en;
    logic                  frame_start;
    blk_pkg::frame_geom_t  geom;
    blk_pkg::wr_progress_t wr_progress;
    logic                  strip_full;
    logic                  near_full;
    logic                  ram_we;
    logic [ADDR_W-1:0]     ram_waddr;
    blk_pkg::pixel_t       ram_wdata;
    blk_pkg::rd_pos_t      rd_pos;
    logic                  rd_step;
    logic                  gap_active;
    logic                  block_end;
    logic                  frame_end;
    logic                  gap_done;
    logic                  pad;
    logic [ADDR_W-1:0]     raddr;

    burst_fsm burst_fsm_i (
        .clk           (clk),
        .rstn          (rstn),
        .frame_done    (frame_done),
        .burst_ready   (burst_ready),
        .wr_valid      (wr_valid),
        .wr_last       (wr_last),
        .wr_progress   (wr_progress),
        .strip_full    (strip_full),
        .near_full     (near_full),
        .burst_valid   (burst_valid),
        .burst_len     (burst_len),
        .wr_data_ready (wr_data_ready),
        .wr_en         (wr_en),
        .frame_start   (frame_start)
    );

    raster_write_counter #(.MAX_BLOCKS_X(MAX_BLOCKS_X)) raster_write_counter_i (
        .clk         (clk),
        .rstn        (rstn),
        .frame_done  (frame_done),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .frame_start (frame_start),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rd_bank     (rd_pos.bank),
        .geom        (geom),
        .wr_progress (wr_progress),
        .strip_full  (strip_full),
        .near_full   (near_full),
        .ram_we      (ram_we),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata)
    );

    block_buffer_ram #(.MAX_BLOCKS_X(MAX_BLOCKS_X)) block_buffer_ram_i (
        .clk       (clk),
        .rstn      (rstn),
        .we        (ram_we),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .rd_step   (rd_step),
        .raddr     (raddr),
        .pad       (pad),
        .block_end (block_end),
        .frame_end (frame_end),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    block_read_fsm block_read_fsm_i (
        .clk                    (clk),
        .rstn                   (rstn),
        .frame_start            (frame_start),
        .downstream_almost_full (downstream_almost_full),
        .wr_progress            (wr_progress),
        .rd_pos                 (rd_pos),
        .block_end              (block_end),
        .frame_end              (frame_end),
        .gap_done               (gap_done),
        .rd_step                (rd_step),
        .gap_active             (gap_active)
    );

    block_read_counter #(
        .MAX_BLOCKS_X (MAX_BLOCKS_X),
        .GAP_CYCLES   (GAP_CYCLES)
    ) block_read_counter_i (
        .clk         (clk),
        .rstn        (rstn),
        .frame_start (frame_start),
        .rd_step     (rd_step),
        .gap_active  (gap_active),
        .geom        (geom),
        .rd_pos      (rd_pos),
        .block_end   (block_end),
        .frame_end   (frame_end),
        .gap_done    (gap_done),
        .pad         (pad),
        .raddr       (raddr)
    );

endmodule

// ==== src/burst_fsm.sv ====
`timescale 1ns/100ps

module burst_fsm (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 frame_done,
    input  logic                 burst_ready,
    input  logic                 wr_valid,
    input  logic                 wr_last,
    input  blk_pkg::wr_progress_t wr_progress,
    input  logic                 strip_full,
    input  logic                 near_full,
    output logic                 burst_valid,
    output logic [7:0]           burst_len,
    output logic                 wr_data_ready,
    output logic                 wr_en,
    output logic                 frame_start
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_DATA
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   frame_done_q;
    logic   frame_rise;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_done_q <= 1'b0;
            state        <= ST_IDLE;
        end else begin
            frame_done_q <= frame_done;
            state        <= state_nxt;
        end
    end

    // rise ends the old frame, fall starts the new one
    assign frame_rise  = frame_done & ~frame_done_q;
    assign frame_start = ~frame_done & frame_done_q;

    // hold the request back while the writer is about to lap the reader
    assign burst_valid   = (state == ST_BURST) && !near_full && !wr_progress.frame_written;
    assign burst_len     = blk_pkg::BURST_LEN;
    assign wr_data_ready = (state == ST_DATA) && !strip_full;
    assign wr_en         = wr_valid && wr_data_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (frame_start) state_nxt = ST_BURST;
            end
            ST_BURST: begin
                if (frame_rise || wr_progress.frame_written) state_nxt = ST_IDLE;
                else if (burst_valid && burst_ready)         state_nxt = ST_DATA;
            end
            ST_DATA: begin
                if (frame_rise || wr_progress.frame_written) state_nxt = ST_IDLE;
                else if (wr_en && wr_last)                   state_nxt = ST_BURST;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

endmodule

// ==== src/raster_write_counter.sv ====
`timescale 1ns/100ps

module raster_write_counter #(
    parameter  int MAX_BLOCKS_X = 256,
    localparam int ADDR_W       = $clog2(MAX_BLOCKS_X * blk_pkg::BLK_PIX) + 1
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          frame_done,
    input  logic [blk_pkg::DIM_W-1:0]     pixel_x,
    input  logic [blk_pkg::DIM_W-1:0]     pixel_y,
    input  logic                          frame_start,
    input  logic                          wr_en,
    input  logic [31:0]                   wr_data,
    input  logic                          rd_bank,
    output blk_pkg::frame_geom_t          geom,
    output blk_pkg::wr_progress_t         wr_progress,
    output logic                          strip_full,
    output logic                          near_full,
    output logic                          ram_we,
    output logic [ADDR_W-1:0]             ram_waddr,
    output blk_pkg::pixel_t               ram_wdata
);

    localparam int COL_W = $clog2(MAX_BLOCKS_X);

    logic                      frame_done_q;
    logic [blk_pkg::DIM_W-1:0] x_cnt;
    logic [blk_pkg::DIM_W-1:0] y_cnt;
    logic                      wr_bank;
    logic                      frame_written;
    logic                      line_end;
    logic                      last_line;
    logic                      last_frame_line;
    logic                      bank_ahead;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_done_q <= 1'b0;
            geom         <= '0;
        end else begin
            frame_done_q <= frame_done;
            // sizes are sampled on the rising edge of frame_done
            if (frame_done && !frame_done_q) begin
                geom.width    <= pixel_x;
                geom.height   <= pixel_y;
                geom.blk_cols <= 9'(({1'b0, pixel_x} + 13'(blk_pkg::BLK_SIDE - 1)) >> 3);
                geom.blk_rows <= 9'(({1'b0, pixel_y} + 13'(blk_pkg::BLK_SIDE - 1)) >> 3);
            end
        end
    end

    assign line_end        = (x_cnt == geom.width - 12'd1);
    assign last_frame_line = (y_cnt == geom.height - 12'd1);
    // a strip ends on line 7 of its block row or on the bottom image line
    assign last_line       = (y_cnt[2:0] == 3'd7) || last_frame_line;

    // raster position
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x_cnt         <= '0;
            y_cnt         <= '0;
            frame_written <= 1'b0;
        end else if (frame_start) begin
            x_cnt         <= '0;
            y_cnt         <= '0;
            frame_written <= 1'b0;
        end else if (wr_en) begin
            if (line_end) begin
                x_cnt <= '0;
                if (last_frame_line) begin
                    y_cnt         <= '0;
                    frame_written <= 1'b1;
                end else begin
                    y_cnt <= y_cnt + 12'd1;
                end
            end else begin
                x_cnt <= x_cnt + 12'd1;
            end
        end
    end

    // bank flips once per strip, so writer and reader stay in step across frames
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_bank <= 1'b0;
        end else if (wr_en && line_end && last_line) begin
            wr_bank <= ~wr_bank;
        end
    end

    assign bank_ahead = (wr_bank != rd_bank);

    // next write would spill into the bank still being read
    assign strip_full = bank_ahead && line_end && last_line;
    assign near_full  = bank_ahead &&
                        ((y_cnt[2:0] >= 3'd5) || ({1'b0, y_cnt} + 13'd3 >= {1'b0, geom.height}));

    assign wr_progress.bank          = wr_bank;
    assign wr_progress.last_line     = last_line;
    assign wr_progress.blk_col       = x_cnt[blk_pkg::DIM_W-1:3];
    assign wr_progress.frame_written = frame_written;

    // block-major layout: bank, block column, row in block, column in block
    assign ram_we    = wr_en;
    assign ram_waddr = {wr_bank, x_cnt[3 +: COL_W], y_cnt[2:0], x_cnt[2:0]};
    assign ram_wdata = wr_data[blk_pkg::PIX_W-1:0];

endmodule

// ==== tests/block_checker.sv ====
`timescale 1ns/100ps

module block_checker #(
    parameter int GAP_CYCLES = 13
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               out_valid,
    input  blk_pkg::out_beat_t out_beat,
    input  logic               burst_valid,
    input  logic               burst_ready,
    input  logic [7:0]         burst_len,
    input  logic               downstream_almost_full,
    input  int                 test_num,
    input  int                 width,
    input  int                 height,
    output int                 frames_seen,
    output int                 err_count,
    output int                 beat_count
);

    int   beat_idx;
    int   idle_cycles;
    int   test_errs;
    logic prev_valid;
    logic seen_block;
    logic af_d1;
    logic af_d2;

    // block-order position back to its raster pixel
    function automatic blk_pkg::out_beat_t expected_beat(input int w, input int h,
                                                         input int blk, input int idx);
        blk_pkg::out_beat_t beat;
        int cols;
        int rows;
        int x;
        int y;
        cols = (w + blk_pkg::BLK_SIDE - 1) / blk_pkg::BLK_SIDE;
        rows = (h + blk_pkg::BLK_SIDE - 1) / blk_pkg::BLK_SIDE;
        x = (blk % cols) * blk_pkg::BLK_SIDE + idx % blk_pkg::BLK_SIDE;
        y = (blk / cols) * blk_pkg::BLK_SIDE + idx / blk_pkg::BLK_SIDE;
        if (x < w && y < h) beat.pixel = 24'(y * 4096 + x);
        else                beat.pixel = 24'h00_0000;
        beat.block_end = (idx == blk_pkg::BLK_PIX - 1);
        beat.frame_end = beat.block_end && (blk == cols * rows - 1);
        return beat;
    endfunction

    always @(posedge clk) begin : compare
        blk_pkg::out_beat_t exp_beat;
        int   errs;
        logic frame_over;
        errs = 0;
        frame_over = 1'b0;
        if (!rstn) begin
            frames_seen <= 0;
            err_count   <= 0;
            beat_count  <= 0;
            af_d1       <= 1'b0;
            af_d2       <= 1'b0;
            beat_idx    = 0;
            idle_cycles = 0;
            test_errs   = 0;
            prev_valid  = 1'b0;
            seen_block  = 1'b0;
        end else begin
            if (burst_valid && burst_ready && burst_len != 8'hff) begin
                $display("ERROR burst_len expected %h got %h", 8'hff, burst_len);
                errs++;
            end
            // first beat of a block
            if (out_valid && !prev_valid) begin
                if (seen_block && idle_cycles < GAP_CYCLES) begin
                    $display("test %0d: block started after only %0d idle cycles",
                             test_num, idle_cycles);
                    errs++;
                end
                if (af_d2) begin
                    $display("test %0d: block started while downstream was almost full",
                             test_num);
                    errs++;
                end
                seen_block = 1'b1;
            end
            if (out_valid) begin
                exp_beat = expected_beat(width, height, beat_idx / blk_pkg::BLK_PIX,
                                         beat_idx % blk_pkg::BLK_PIX);
                if (out_beat.pixel !== exp_beat.pixel) begin
                    $display("ERROR out_beat.pixel expected %h got %h (test %0d, beat %0d)",
                             exp_beat.pixel, out_beat.pixel, test_num, beat_idx);
                    errs++;
                end
                if (out_beat.block_end !== exp_beat.block_end) begin
                    $display("ERROR out_beat.block_end expected %h got %h (test %0d, beat %0d)",
                             exp_beat.block_end, out_beat.block_end, test_num, beat_idx);
                    errs++;
                end
                if (out_beat.frame_end !== exp_beat.frame_end) begin
                    $display("ERROR out_beat.frame_end expected %h got %h (test %0d, beat %0d)",
                             exp_beat.frame_end, out_beat.frame_end, test_num, beat_idx);
                    errs++;
                end
                beat_idx++;
                idle_cycles = 0;
                frame_over = exp_beat.frame_end;
            end else begin
                idle_cycles++;
            end
            test_errs = test_errs + errs;
            if (frame_over) begin
                $display("test %0d, %0dx%0d frame: %0d beats, %0d errors",
                         test_num, width, height, beat_idx, test_errs);
                frames_seen <= frames_seen + 1;
                beat_idx  = 0;
                test_errs = 0;
            end
            err_count  <= err_count + errs;
            beat_count <= beat_count + (out_valid ? 1 : 0);
            prev_valid = out_valid;
            af_d2 <= af_d1;
            af_d1 <= downstream_almost_full;
        end
    end

endmodule

// ==== tests/block_reorder_assertions.sv ====
`timescale 1ns/100ps

module block_reorder_assertions (
    input logic clk,
    input logic rstn,
    input logic burst_valid,
    input logic burst_ready,
    input logic wr_data_ready,
    input logic out_valid
);

    int         hold_fails = 0;
    int         excl_fails = 0;
    int         run_fails  = 0;
    logic [6:0] run_len;

    // consecutive out_valid cycles so far
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)          run_len <= '0;
        else if (out_valid) run_len <= run_len + 7'd1;
        else                run_len <= '0;
    end

    hold_request: assert property (@(posedge clk) disable iff (!rstn)
        (burst_valid && !burst_ready) |=> burst_valid)
    else begin
        hold_fails++;
        $error("burst_valid dropped before it was accepted");
    end

    // request phase and data phase never overlap
    request_or_data: assert property (@(posedge clk) disable iff (!rstn)
        !(burst_valid && wr_data_ready))
    else begin
        excl_fails++;
        $error("wr_data_ready high while burst_valid is high");
    end

    // a block is exactly 64 beats long
    block_run: assert property (@(posedge clk) disable iff (!rstn)
        (run_len != 7'd0) |-> (out_valid == (run_len < 7'd64)))
    else begin
        run_fails++;
        $error("out_valid run is not 64 cycles long");
    end

endmodule

// ==== tests/tb_block_reorder.sv ====
`timescale 1ns/100ps

module tb_block_reorder;

    localparam int MAX_BLOCKS_X = 256;
    localparam int GAP_CYCLES   = 13;
    localparam int NUM_TESTS    = 5;
    localparam int HOLD_CYCLES  = 300;
    // four cycles per pixel, a full block slot per block, plus setup slack
    localparam int TOTAL_PIX    = 16 * 16 + 13 * 10 + 40 * 24 + 24 * 16 + 21 * 9;
    localparam int TOTAL_BLK    = 4 + 4 + 15 + 6 + 6;
    localparam int CYCLE_LIMIT  = TOTAL_PIX * 4 + TOTAL_BLK * (GAP_CYCLES + 70)
                                  + HOLD_CYCLES + 200;

    logic               clk                    = 1'b0;
    logic               rstn                   = 1'b0;
    logic               frame_done             = 1'b0;
    logic [11:0]        pixel_x                = '0;
    logic [11:0]        pixel_y                = '0;
    logic               burst_ready            = 1'b0;
    logic               wr_valid               = 1'b0;
    logic [31:0]        wr_data                = '0;
    logic               wr_last                = 1'b0;
    logic               downstream_almost_full = 1'b0;
    logic               burst_valid;
    logic [7:0]         burst_len;
    logic               wr_data_ready;
    logic               out_valid;
    blk_pkg::out_beat_t out_beat;

    int   seed        = 32'h884c_4ce2;
    int   src_width   = 1;
    int   src_total   = 0;
    int   stall_level = 0;
    int   src_idx     = 0;
    int   burst_words = 0;
    logic granted     = 1'b0;
    int   test_num    = 0;
    int   exp_width   = 1;
    int   exp_height  = 1;
    int   cycle_count = 0;
    int   frames_seen;
    int   err_count;
    int   beat_count;

    always #2 clk = ~clk;

    block_reorder_top #(
        .MAX_BLOCKS_X (MAX_BLOCKS_X),
        .GAP_CYCLES   (GAP_CYCLES)
    ) dut_i (
        .clk                    (clk),
        .rstn                   (rstn),
        .frame_done             (frame_done),
        .pixel_x                (pixel_x),
        .pixel_y                (pixel_y),
        .burst_valid            (burst_valid),
        .burst_len              (burst_len),
        .burst_ready            (burst_ready),
        .wr_valid               (wr_valid),
        .wr_data                (wr_data),
        .wr_last                (wr_last),
        .wr_data_ready          (wr_data_ready),
        .downstream_almost_full (downstream_almost_full),
        .out_valid              (out_valid),
        .out_beat               (out_beat)
    );

    bind block_reorder_top block_reorder_assertions assert_i (
        .clk           (clk),
        .rstn          (rstn),
        .burst_valid   (burst_valid),
        .burst_ready   (burst_ready),
        .wr_data_ready (wr_data_ready),
        .out_valid     (out_valid)
    );

    block_checker #(.GAP_CYCLES(GAP_CYCLES)) checker_i (
        .clk                    (clk),
        .rstn                   (rstn),
        .out_valid              (out_valid),
        .out_beat               (out_beat),
        .burst_valid            (burst_valid),
        .burst_ready            (burst_ready),
        .burst_len              (burst_len),
        .downstream_almost_full (downstream_almost_full),
        .test_num               (test_num),
        .width                  (exp_width),
        .height                 (exp_height),
        .frames_seen            (frames_seen),
        .err_count              (err_count),
        .beat_count             (beat_count)
    );

    // raster pixel source, value y*4096 + x
    always @(posedge clk) begin : pixel_source
        int   next_idx;
        int   words;
        int   rnd;
        logic g;
        next_idx = src_idx;
        words = burst_words;
        g = granted;
        if (!rstn || frame_done) begin
            src_idx     <= 0;
            burst_words <= 0;
            granted     <= 1'b0;
            burst_ready <= 1'b0;
            wr_valid    <= 1'b0;
            wr_last     <= 1'b0;
        end else begin
            rnd = $random(seed);
            if (wr_valid && wr_data_ready) begin
                next_idx = src_idx + 1;
                words = burst_words + 1;
                if (wr_last) g = 1'b0;
            end
            if (burst_valid && burst_ready) begin
                g = 1'b1;
                words = 0;
            end
            burst_ready <= (rnd & 3) != 0;
            if (g && next_idx < src_total) begin
                wr_data  <= 32'((next_idx / src_width) * 4096 + next_idx % src_width);
                wr_last  <= (words == 254) || (next_idx == src_total - 1);
                // a word not yet taken stays valid
                wr_valid <= (wr_valid && !wr_data_ready) || (((rnd >> 2) & 7) >= stall_level);
            end else begin
                wr_valid <= 1'b0;
            end
            src_idx     <= next_idx;
            burst_words <= words;
            granted     <= g;
        end
    end

    task automatic run_frame(input int num, input int w, input int h, input int stall,
                             input logic hold);
        int frames_before;
        frames_before = frames_seen;
        test_num    <= num;
        exp_width   <= w;
        exp_height  <= h;
        src_width   <= w;
        src_total   <= w * h;
        stall_level <= stall;
        pixel_x     <= 12'(w);
        pixel_y     <= 12'(h);
        frame_done  <= 1'b1;
        repeat (3) @(posedge clk);
        // falling edge starts the frame
        frame_done <= 1'b0;
        if (hold) begin
            while (!out_valid) @(posedge clk);
            downstream_almost_full <= 1'b1;
            repeat (HOLD_CYCLES) @(posedge clk);
            downstream_almost_full <= 1'b0;
        end
        while (frames_seen == frames_before) @(posedge clk);
    endtask

    initial begin
        int assert_fails;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        run_frame(1, 16, 16, 0, 1'b0);
        run_frame(2, 13, 10, 0, 1'b0);
        run_frame(3, 40, 24, 3, 1'b0);
        run_frame(4, 24, 16, 1, 1'b1);
        run_frame(5, 21, 9, 2, 1'b0);
        assert_fails = dut_i.assert_i.hold_fails + dut_i.assert_i.excl_fails
                       + dut_i.assert_i.run_fails;
        $display("%0d of %0d tests done, %0d beats checked, %0d errors, %0d assertion failures",
                 frames_seen, NUM_TESTS, beat_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0 && frames_seen == NUM_TESTS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles, stopped in test %0d",
                     CYCLE_LIMIT, test_num);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule
